//--- hdl/usb_proto_pkg.sv
// USB protocol definitions
`default_nettype none

package usb_proto_pkg;

    // Packet identifiers as carried in the low nibble of the PID byte
    typedef enum logic [3:0] {
        PID_OUT   = 4'b0001,
        PID_IN    = 4'b1001,
        PID_SOF   = 4'b0101,
        PID_SETUP = 4'b1101,
        PID_DATA0 = 4'b0011,
        PID_DATA1 = 4'b1011,
        PID_ACK   = 4'b0010,
        PID_NAK   = 4'b1010,
        PID_STALL = 4'b1110
    } usb_pid_e;

    // Remainders left in a checker after a good packet has been shifted in with its CRC
    localparam logic [4:0]  CRC5_RESIDUAL  = 5'b0_1100;
    localparam logic [15:0] CRC16_RESIDUAL = 16'b1000_0000_0000_1101;

    // Decoded SYNC, first bit on the wire in bit 0
    localparam logic [7:0] SYNC_PATTERN = 8'b1000_0000;

    // Token and SOF packets carry an 11 bit field and a CRC5
    function automatic logic pid_is_token(input logic [3:0] pid);
        return pid inside {PID_OUT, PID_IN, PID_SOF, PID_SETUP};
    endfunction

    function automatic logic pid_is_data(input logic [3:0] pid);
        return pid inside {PID_DATA0, PID_DATA1};
    endfunction

    // Handshakes end right after the PID
    function automatic logic pid_is_handshake(input logic [3:0] pid);
        return pid inside {PID_ACK, PID_NAK, PID_STALL};
    endfunction

    function automatic logic pid_is_known(input logic [3:0] pid);
        return pid_is_token(pid) || pid_is_data(pid) || pid_is_handshake(pid);
    endfunction

endpackage

`default_nettype wire

//--- hdl/usb_rx_pkg.sv
// Receiver internal definitions
`default_nettype none

package usb_rx_pkg;

    // Packet decoder states
    typedef enum logic [1:0] {
        IDLE,
        PID,
        PAYLOAD,
        DRAIN
    } dec_state_e;

    // A stuffed zero follows this many ones on the wire
    localparam int STUFF_RUN = 6;
    localparam int RUN_W     = $clog2(STUFF_RUN + 1);

    // Field widths of a packet
    localparam int PID_BITS      = 8;
    localparam int FIELD_BITS    = 11;
    localparam int TOKEN_BITS    = 16;
    localparam int ADDR_W        = 7;
    localparam int ENDP_W        = 4;
    localparam int DATA_MIN_BITS = 16;

    // Enough for a 1023 byte payload plus its CRC16
    localparam int BIT_CNT_W = 14;

endpackage

`default_nettype wire

//--- hdl/usb_bit_if.sv
// Unstuffed bit stream link
`default_nettype none
`timescale 1ns/1ps

interface usb_bit_if;

    // Every signal is a one cycle pulse except data, which is qualified by valid
    logic data;
    logic valid;
    logic sop;
    logic eop;
    logic stuff_err;

    // Line stage side
    modport src (output data, valid, sop, eop, stuff_err);

    // Packet decoder side
    modport snk (input data, valid, sop, eop, stuff_err);

endinterface

`default_nettype wire

//--- hdl/usb_nrzi_rx.sv
// USB receive line stage
`default_nettype none
`timescale 1ns/1ps

module usb_nrzi_rx (
    input  logic   clk12_i,
    input  logic   rst_i,
    input  logic   bit_strobe_i,
    input  logic   dp_i,
    input  logic   se0_i,
    usb_bit_if.src bit_o
);

    import usb_proto_pkg::*;
    import usb_rx_pkg::*;

    logic             last_dp_q;
    logic             in_pkt_q;
    logic [7:0]       window_q;
    logic [RUN_W-1:0] ones_q;
    logic             nrzi_bit;
    logic [7:0]       window_next;
    logic             stuffed_slot;

    // An unchanged line level decodes to a one, a transition to a zero
    assign nrzi_bit = (dp_i == last_dp_q);

    // Bits arrive least significant first, so they enter the window at the top
    assign window_next = {nrzi_bit, window_q[7:1]};

    // After a full run of ones the next bit on the wire must be a stuffed zero
    assign stuffed_slot = (ones_q == RUN_W'(STUFF_RUN));

    always_ff @(posedge clk12_i) begin
        // Interface strobes are high for one cycle only
        bit_o.valid     <= 1'b0;
        bit_o.sop       <= 1'b0;
        bit_o.eop       <= 1'b0;
        bit_o.stuff_err <= 1'b0;

        if (rst_i) begin
            // The idle bus sits at J, which reads as a high level
            last_dp_q <= 1'b1;
            in_pkt_q  <= 1'b0;
            // Idle J decodes to ones, so the hunt window starts full of them
            window_q  <= '1;
            ones_q    <= '0;
        end else if (bit_strobe_i) begin
            if (se0_i) begin
                // SE0 ends a packet and the bus returns to J afterwards
                bit_o.eop <= in_pkt_q;
                in_pkt_q  <= 1'b0;
                last_dp_q <= 1'b1;
                window_q  <= '1;
            end else begin
                last_dp_q <= dp_i;

                if (!in_pkt_q) begin
                    // Hunting for SYNC
                    window_q <= window_next;
                    if (window_next == SYNC_PATTERN) begin
                        bit_o.sop <= 1'b1;
                        in_pkt_q  <= 1'b1;
                        // The final one of SYNC already counts toward the stuffing run
                        ones_q    <= RUN_W'(1);
                    end
                end else if (stuffed_slot) begin
                    // A zero here is the stuffed bit and is dropped
                    // A one here means the transmitter broke the stuffing rule
                    bit_o.stuff_err <= nrzi_bit;
                    ones_q          <= '0;
                end else begin
                    bit_o.valid <= 1'b1;
                    bit_o.data  <= nrzi_bit;
                    if (nrzi_bit) begin
                        ones_q <= ones_q + 1'b1;
                    end else begin
                        ones_q <= '0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/usb_crc.sv
// Serial USB CRC register
`default_nettype none
`timescale 1ns/1ps

module usb_crc (
    input  logic        clk12_i,
    input  logic        rst_i,
    input  logic        valid_i,
    input  logic        use_crc16_i,
    input  logic        data_i,
    output logic        crc_valid_o,
    output logic [15:0] crc_o
);

    import usb_proto_pkg::*;

    logic [15:0] crc_q;
    logic [15:0] crc_next;
    logic        use_crc16_q;
    logic        feedback;

    // The top bit of the active register width is folded with the incoming bit
    assign feedback = data_i ^ (use_crc16_q ? crc_q[15] : crc_q[4]);

    // A generator sends the inverted remainder most significant bit first
    // The next value is used so the last data bit is already included
    assign crc_o = ~crc_next;

    // A good packet leaves the fixed residual of its polynomial behind
    assign crc_valid_o = use_crc16_q ? (crc_q == CRC16_RESIDUAL)
                                     : (crc_q[4:0] == CRC5_RESIDUAL);

    always_comb begin
        crc_next = crc_q;
        if (valid_i) begin
            // CRC5 is x^5 + x^2 + 1 and CRC16 is x^16 + x^15 + x^2 + 1
            // Both share the taps at bits 0 and 2
            // Bit 15 only matters for CRC16 and CRC5 ignores the upper bits
            crc_next = {
                crc_q[14] ^ feedback,
                crc_q[13:2],
                crc_q[1] ^ feedback,
                crc_q[0],
                feedback
            };
        end
    end

    always_ff @(posedge clk12_i) begin
        if (rst_i) begin
            // Seed with all ones and sample the polynomial choice while held in reset
            crc_q       <= '1;
            use_crc16_q <= use_crc16_i;
        end else begin
            crc_q <= crc_next;
        end
    end

endmodule

`default_nettype wire

//--- hdl/usb_packet_decoder.sv
// USB receive packet decoder
`default_nettype none
`timescale 1ns/1ps

module usb_packet_decoder (
    input  logic                              clk12_i,
    input  logic                              rst_i,
    usb_bit_if.snk                            bit_i,
    output usb_proto_pkg::usb_pid_e           pid_o,
    output logic [usb_rx_pkg::ADDR_W-1:0]     addr_o,
    output logic [usb_rx_pkg::ENDP_W-1:0]     endp_o,
    output logic [usb_rx_pkg::FIELD_BITS-1:0] frame_o,
    output logic [7:0]                        data_o,
    output logic                              data_valid_o,
    output logic                              pkt_done_o,
    output logic                              crc_err_o,
    output logic                              pid_err_o,
    output logic                              fmt_err_o,
    output logic                              stuff_err_o
);

    import usb_proto_pkg::*;
    import usb_rx_pkg::*;

    dec_state_e            state_q;
    usb_pid_e              pid_q;
    logic [PID_BITS-1:0]   pid_sr_q;
    logic [PID_BITS-1:0]   pid_byte;
    logic [BIT_CNT_W-1:0]  bit_cnt_q;
    logic [FIELD_BITS-1:0] field_q;
    logic [2:0][7:0]       line_q;
    logic [7:0]            byte_done;
    logic [1:0]            held_q;
    logic                  pid_bad_q;
    logic                  stuff_seen_q;
    logic                  pid_last;
    logic                  byte_end;
    logic                  crc_rst;
    logic                  crc_ok;
    logic                  len_bad;
    logic                  crc_bad;

    // The PID byte completes with the current bit, complement nibble on top
    assign pid_byte = {bit_i.data, pid_sr_q[PID_BITS-1:1]};
    assign pid_last = (state_q == PID) && bit_i.valid && (bit_cnt_q[2:0] == 3'd7);

    // Slot 0 of the holding line assembles bytes, slots 1 and 2 keep the two latest
    assign byte_done = {bit_i.data, line_q[0][7:1]};
    assign byte_end  = (state_q == PAYLOAD) && bit_i.valid && (bit_cnt_q[2:0] == 3'd7);

    // The CRC register stays seeded outside the payload
    assign crc_rst = rst_i || (state_q != PAYLOAD);

    // The expected length depends only on the PID class
    always_comb begin
        len_bad = 1'b0;
        if (pid_is_handshake(pid_q)) begin
            len_bad = (bit_cnt_q != '0);
        end else if (pid_is_token(pid_q)) begin
            len_bad = (bit_cnt_q != BIT_CNT_W'(TOKEN_BITS));
        end else if (pid_is_data(pid_q)) begin
            len_bad = (bit_cnt_q < BIT_CNT_W'(DATA_MIN_BITS)) || (bit_cnt_q[2:0] != 3'd0);
        end
    end

    // Handshakes carry no CRC
    assign crc_bad = (pid_is_token(pid_q) || pid_is_data(pid_q)) && !crc_ok;

    // The PID byte picks the polynomial on its last bit, while the CRC is still in reset
    usb_crc u_crc (
        .clk12_i     (clk12_i),
        .rst_i       (crc_rst),
        .valid_i     (bit_i.valid && (state_q == PAYLOAD)),
        .use_crc16_i (pid_is_data(pid_byte[3:0])),
        .data_i      (bit_i.data),
        .crc_valid_o (crc_ok),
        .crc_o       ()
    );

    always_ff @(posedge clk12_i) begin
        data_valid_o <= 1'b0;
        pkt_done_o   <= 1'b0;

        if (rst_i) begin
            state_q      <= IDLE;
            bit_cnt_q    <= '0;
            held_q       <= '0;
            pid_bad_q    <= 1'b0;
            stuff_seen_q <= 1'b0;
            crc_err_o    <= 1'b0;
            pid_err_o    <= 1'b0;
            fmt_err_o    <= 1'b0;
            stuff_err_o  <= 1'b0;
        end else if (bit_i.sop) begin
            state_q      <= PID;
            bit_cnt_q    <= '0;
            held_q       <= '0;
            stuff_seen_q <= 1'b0;
        end else if (bit_i.eop) begin
            state_q     <= IDLE;
            pkt_done_o  <= (state_q != IDLE);
            stuff_err_o <= stuff_seen_q;
            if (state_q == PID) begin
                // The packet ended inside its PID byte
                pid_err_o <= 1'b1;
                fmt_err_o <= 1'b1;
                crc_err_o <= 1'b0;
            end else begin
                pid_err_o <= pid_bad_q;
                fmt_err_o <= len_bad;
                crc_err_o <= crc_bad;
            end
        end else if (bit_i.stuff_err && (state_q != IDLE)) begin
            // The rest of the packet cannot be trusted, so wait for its end
            stuff_seen_q <= 1'b1;
            state_q      <= DRAIN;
            if (state_q == PID) begin
                pid_bad_q <= 1'b1;
            end
        end else if (bit_i.valid) begin
            case (state_q)
                PID: begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                    if (pid_last) begin
                        state_q   <= PAYLOAD;
                        bit_cnt_q <= '0;
                        pid_bad_q <= (pid_byte[3:0] != ~pid_byte[7:4]) ||
                                     !pid_is_known(pid_byte[3:0]);
                    end
                end
                PAYLOAD: begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                    // Only data payload is released, and only with two newer bytes behind it
                    if (byte_end && pid_is_data(pid_q)) begin
                        if (held_q == 2'd2) begin
                            data_valid_o <= 1'b1;
                        end else begin
                            held_q <= held_q + 1'b1;
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Payload registers follow the stream without a reset
    always_ff @(posedge clk12_i) begin
        if (bit_i.valid && (state_q == PID)) begin
            pid_sr_q <= pid_byte;
        end
        if (pid_last) begin
            pid_q <= usb_pid_e'(pid_byte[3:0]);
        end
        if (bit_i.valid && (state_q == PAYLOAD)) begin
            line_q[0] <= byte_done;
            // Token fields are sent least significant bit first
            if (bit_cnt_q < BIT_CNT_W'(FIELD_BITS)) begin
                field_q <= {bit_i.data, field_q[FIELD_BITS-1:1]};
            end
        end
        if (byte_end) begin
            data_o    <= line_q[2];
            line_q[2] <= line_q[1];
            line_q[1] <= byte_done;
        end
        // Packet fields settle together with pkt_done_o
        if (bit_i.eop) begin
            pid_o   <= pid_q;
            addr_o  <= field_q[ADDR_W-1:0];
            endp_o  <= field_q[FIELD_BITS-1:ADDR_W];
            frame_o <= field_q;
        end
    end

endmodule

`default_nettype wire

//--- hdl/usb_rx_top.sv
// USB full-speed receiver
`default_nettype none
`timescale 1ns/1ps

module usb_rx_top (
    input  logic                              clk12_i,
    input  logic                              rst_i,
    input  logic                              bit_strobe_i,
    input  logic                              dp_i,
    input  logic                              se0_i,
    output usb_proto_pkg::usb_pid_e           pid_o,
    output logic [usb_rx_pkg::ADDR_W-1:0]     addr_o,
    output logic [usb_rx_pkg::ENDP_W-1:0]     endp_o,
    output logic [usb_rx_pkg::FIELD_BITS-1:0] frame_o,
    output logic [7:0]                        data_o,
    output logic                              data_valid_o,
    output logic                              pkt_done_o,
    output logic                              crc_err_o,
    output logic                              pid_err_o,
    output logic                              fmt_err_o,
    output logic                              stuff_err_o
);

    // Unstuffed bits from the line stage to the decoder
    usb_bit_if u_bit_if ();

    usb_nrzi_rx u_nrzi_rx (
        .clk12_i      (clk12_i),
        .rst_i        (rst_i),
        .bit_strobe_i (bit_strobe_i),
        .dp_i         (dp_i),
        .se0_i        (se0_i),
        .bit_o        (u_bit_if.src)
    );

    usb_packet_decoder u_packet_decoder (
        .clk12_i      (clk12_i),
        .rst_i        (rst_i),
        .bit_i        (u_bit_if.snk),
        .pid_o        (pid_o),
        .addr_o       (addr_o),
        .endp_o       (endp_o),
        .frame_o      (frame_o),
        .data_o       (data_o),
        .data_valid_o (data_valid_o),
        .pkt_done_o   (pkt_done_o),
        .crc_err_o    (crc_err_o),
        .pid_err_o    (pid_err_o),
        .fmt_err_o    (fmt_err_o),
        .stuff_err_o  (stuff_err_o)
    );

endmodule

`default_nettype wire

//--- test/usb_rx_model.svh
// USB packet builder and reference model

// Decoded bits after the PID, before stuffing
bit body_bits[$];
// Decoded bits of the whole packet after stuffing
bit wire_bits[$];
// Level of dp for each strobe of the packet
bit line_levels[$];

// Fields and bytes go out least significant bit first
task automatic push_field(input logic [15:0] value, input int width);
    for (int i = 0; i < width; i++) begin
        body_bits.push_back(value[i]);
    end
endtask

// Serial CRC over the body, seeded with all ones
// CRC5 uses x^5 + x^2 + 1 and CRC16 uses x^16 + x^15 + x^2 + 1
function automatic logic [15:0] crc_register(input bit use16);
    logic [15:0] crc;
    logic [15:0] poly;
    logic        fb;
    int          top;
    crc  = '1;
    poly = use16 ? 16'h8005 : 16'h0005;
    top  = use16 ? 15 : 4;
    foreach (body_bits[i]) begin
        fb  = body_bits[i] ^ crc[top];
        crc = crc << 1;
        if (fb) begin
            crc = crc ^ poly;
        end
    end
    return use16 ? crc : {11'd0, crc[4:0]};
endfunction

// The inverted remainder is sent most significant bit first
task automatic append_crc(input bit use16);
    logic [15:0] rem;
    rem = ~crc_register(use16);
    for (int i = (use16 ? 15 : 4); i >= 0; i--) begin
        body_bits.push_back(rem[i]);
    end
    // Running the register over data and CRC together leaves the residual
    check_value("crc residual", use16 ? CRC16_RESIDUAL : 16'(CRC5_RESIDUAL),
                crc_register(use16));
endtask

// SYNC and PID lead the body, and a zero follows every run of six ones
task automatic stuff_packet(input logic [7:0] pid_byte);
    bit          raw[$];
    logic [15:0] head;
    int          ones;
    head = {pid_byte, SYNC_PATTERN};
    ones = 0;
    wire_bits.delete();
    for (int i = 0; i < 16; i++) begin
        raw.push_back(head[i]);
    end
    foreach (body_bits[i]) begin
        raw.push_back(body_bits[i]);
    end
    foreach (raw[i]) begin
        wire_bits.push_back(raw[i]);
        ones = raw[i] ? ones + 1 : 0;
        if (ones == STUFF_RUN) begin
            wire_bits.push_back(1'b0);
            ones = 0;
        end
    end
endtask

// A one keeps the level and a zero toggles it, starting from idle J
task automatic nrzi_encode();
    bit level;
    level = 1'b1;
    line_levels.delete();
    foreach (wire_bits[i]) begin
        if (!wire_bits[i]) begin
            level = ~level;
        end
        line_levels.push_back(level);
    end
endtask

//--- test/usb_rx_tb.sv
// USB receiver testbench
`default_nettype none
`timescale 1ns/1ps

module usb_rx_tb;

    import usb_proto_pkg::*;
    import usb_rx_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int PACKETS    = 200;
    // SYNC, PID, 16 bytes with CRC16, stuffing, idle, violation and EOP strobes
    localparam int LONGEST     = 8 + 8 + 144 + 144 / STUFF_RUN + 3 + 8 + 2;
    localparam int WATCHDOG_NS = PACKETS * LONGEST * 4 * CLK_PERIOD;

    logic        clk12;
    logic        rst;
    logic        bit_strobe;
    logic        dp;
    logic        se0;
    usb_pid_e    pid;
    logic [6:0]  addr;
    logic [3:0]  endp;
    logic [10:0] frame;
    logic [7:0]  data;
    logic        data_valid;
    logic        pkt_done;
    logic        crc_err;
    logic        pid_err;
    logic        fmt_err;
    logic        stuff_err;

    // Decoder outputs captured at the end of each packet
    int          done_cnt;
    logic [3:0]  got_flags;
    usb_pid_e    got_pid;
    logic [10:0] got_addr_endp;
    logic [10:0] got_frame;
    logic [7:0]  rx_bytes[$];

    `include "usb_rx_model.svh"

    usb_rx_top u_dut (
        .clk12_i      (clk12),
        .rst_i        (rst),
        .bit_strobe_i (bit_strobe),
        .dp_i         (dp),
        .se0_i        (se0),
        .pid_o        (pid),
        .addr_o       (addr),
        .endp_o       (endp),
        .frame_o      (frame),
        .data_o       (data),
        .data_valid_o (data_valid),
        .pkt_done_o   (pkt_done),
        .crc_err_o    (crc_err),
        .pid_err_o    (pid_err),
        .fmt_err_o    (fmt_err),
        .stuff_err_o  (stuff_err)
    );

    always #(CLK_PERIOD / 2) clk12 = ~clk12;

    // Outputs are sampled on the falling edge, well away from their updates
    always @(negedge clk12) begin
        if (data_valid) begin
            rx_bytes.push_back(data);
        end
        if (pkt_done) begin
            got_flags     = {crc_err, pid_err, fmt_err, stuff_err};
            got_pid       = pid;
            got_addr_endp = {endp, addr};
            got_frame     = frame;
            done_cnt++;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            abort_run("First mismatch ends the run");
        end
    endtask

    // One strobe, then 0 to 3 idle cycles, with inputs moving 2 ns after the edge
    task automatic drive_strobe(input bit level, input bit is_se0);
        int gap;
        gap = $urandom_range(3, 0);
        bit_strobe = 1'b1;
        dp         = level;
        se0        = is_se0;
        @(posedge clk12);
        #2;
        bit_strobe = 1'b0;
        repeat (gap) begin
            @(posedge clk12);
            #2;
        end
    endtask

    // Idle J bits, the packet itself, then two SE0 strobes as EOP
    task automatic send_line();
        repeat ($urandom_range(3, 1)) drive_strobe(1'b1, 1'b0);
        foreach (line_levels[i]) drive_strobe(line_levels[i], 1'b0);
        repeat (2) drive_strobe(1'b0, 1'b1);
    endtask

    task automatic wait_done(input int target);
        int cycles;
        cycles = 0;
        while (done_cnt < target) begin
            if (cycles == 8) begin
                abort_run("No pkt_done_o arrived within 8 cycles of the EOP");
            end
            @(posedge clk12);
            #2;
            cycles++;
        end
    endtask

    // Class 0 is a token or SOF, class 1 a data packet, class 2 a handshake
    function automatic usb_pid_e random_pid(input int cls);
        int r;
        r = $urandom_range(3, 0);
        case (cls)
            0: return usb_pid_e'({r[1:0], 2'b01});
            1: return r[0] ? PID_DATA1 : PID_DATA0;
            default: return (r == 0) ? PID_ACK : (r == 1) ? PID_NAK : PID_STALL;
        endcase
    endfunction

    task automatic run_packet(input int kind);
        usb_pid_e    p;
        logic [7:0]  pid_byte;
        logic [10:0] field;
        logic [3:0]  exp_flags;
        logic [3:0]  flag_mask;
        logic [7:0]  payload[$];
        int          cls;
        int          idx;
        int          target;
        // Kinds 0 to 3 are clean packets and kinds 4 to 6 carry one fault each
        case (kind)
            0: cls = 0;
            1: cls = 1;
            2, 3: cls = 2;
            4: cls = $urandom_range(1, 0);
            default: cls = $urandom_range(2, 0);
        endcase
        p         = random_pid(cls);
        field     = 11'($urandom);
        exp_flags = '0;
        flag_mask = '1;
        body_bits.delete();
        if (cls == 0) begin
            push_field(16'(field), FIELD_BITS);
            append_crc(1'b0);
            check_value("token length", TOKEN_BITS, body_bits.size());
        end else if (cls == 1) begin
            repeat ($urandom_range(16, 0)) begin
                payload.push_back(8'($urandom));
                push_field(16'(payload[$]), 8);
            end
            append_crc(1'b1);
        end else if (kind == 3) begin
            // A handshake must end right after its PID
            push_field(16'($urandom), 8);
            exp_flags[1] = 1'b1;
        end
        pid_byte = {~4'(p), 4'(p)};
        if (kind == 4) begin
            idx            = $urandom_range(body_bits.size() - 1, 0);
            body_bits[idx] = !body_bits[idx];
            exp_flags[3]   = 1'b1;
        end else if (kind == 5) begin
            idx           = 4 + $urandom_range(3, 0);
            pid_byte[idx] = !pid_byte[idx];
            exp_flags[2]  = 1'b1;
        end
        stuff_packet(pid_byte);
        if (kind == 6) begin
            // A zero clears the run, then seven ones arrive with no stuffed zero
            wire_bits.push_back(1'b0);
            repeat (7) wire_bits.push_back(1'b1);
            exp_flags = 4'b0001;
            flag_mask = 4'b0001;
        end
        nrzi_encode();
        target = done_cnt + 1;
        rx_bytes.delete();
        send_line();
        wait_done(target);
        check_value("pid", 32'(p), 32'(got_pid));
        check_value("error flags", 32'(exp_flags), 32'(got_flags & flag_mask));
        if (kind == 0) begin
            check_value("token field", 32'(field),
                        32'((p == PID_SOF) ? got_frame : got_addr_endp));
        end
        if (cls == 1 && kind != 4) begin
            check_value("byte count", payload.size(), rx_bytes.size());
            foreach (payload[i]) check_value("data byte", payload[i], rx_bytes[i]);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run("The watchdog expired before all packets were checked");
    end

    initial begin
        void'($urandom(89));
        clk12      = 1'b0;
        rst        = 1'b1;
        bit_strobe = 1'b0;
        dp         = 1'b1;
        se0        = 1'b0;
        done_cnt   = 0;
        repeat (5) @(posedge clk12);
        #2;
        rst = 1'b0;
        check_value("outputs after reset", 0,
                    {pkt_done, data_valid, crc_err, pid_err, fmt_err, stuff_err});
        for (int n = 0; n < PACKETS; n++) begin
            run_packet($urandom_range(6, 0));
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+test
hdl/usb_proto_pkg.sv
hdl/usb_rx_pkg.sv
hdl/usb_bit_if.sv
hdl/usb_nrzi_rx.sv
hdl/usb_crc.sv
hdl/usb_packet_decoder.sv
hdl/usb_rx_top.sv
test/usb_rx_tb.sv
